// ==== display_timing.sv ====
/* raster counters for a 32x24 active area in a 40x28 frame
   sync outputs are active high, line_arm pulses once per line */
`include "sprite_defines.svh"

module display_timing (
    input  logic                clk,
    input  logic                rst,
    output sprite_pkg::coord_t  sx,        // horizontal position
    output sprite_pkg::coord_t  sy,        // vertical position
    output logic                hsync,
    output logic                vsync,
    output logic                de,        // active area
    output logic                line_arm   // first blanking pixel of the line
);

    localparam int HS_START = `H_ACTIVE + `H_FRONT;  // 34
    localparam int HS_END   = HS_START + `H_SYNC;    // first pixel after sync
    localparam int VS_START = `V_ACTIVE + `V_FRONT;  // 25
    localparam int VS_END   = VS_START + `V_SYNC;

    logic line_end;   // last pixel of line
    logic frame_end;  // last line of frame

    assign line_end  = (sx == sprite_pkg::coord_t'(`H_TOTAL - 1));
    assign frame_end = (sy == sprite_pkg::coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;  // wrap line
            sy <= frame_end ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync and enable decode straight from counters
    always_comb begin
        hsync    = (sx >= HS_START) && (sx < HS_END);
        vsync    = (sy >= VS_START) && (sy < VS_END);
        de       = (sx < `H_ACTIVE) && (sy < `V_ACTIVE);
        line_arm = (sx == sprite_pkg::coord_t'(`H_ACTIVE));
    end

    // counters never leave the frame
    a_raster_range: assert property (
        @(posedge clk) disable iff (rst)
        (sx < `H_TOTAL) && (sy < `V_TOTAL)
    );

endmodule

// ==== pixel_mixer.sv ====
/* output stage, picks sprite or background colour per pixel
   all outputs lag the raster by one cycle, colour is 0 in blanking */
module pixel_mixer (
    input  logic                    clk,
    input  logic                    rst,
    sprite_cfg_if.mixer             cfg,
    input  logic                    pix,       // sprite pixel on
    input  logic                    hsync_in,
    input  logic                    vsync_in,
    input  logic                    de_in,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output sprite_pkg::colour_t     colour
);

    sprite_pkg::colour_t colour_next;

    always_comb begin
        if (!de_in) begin
            colour_next = '0;  // blanking
        end else if (pix) begin
            colour_next = cfg.spr_colour;
        end else begin
            colour_next = cfg.bg_colour;
        end
    end

    // sync and colour kept aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            de     <= 1'b0;
            colour <= '0;
        end else begin
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            de     <= de_in;
            colour <= colour_next;
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
sprite_pkg.sv
sprite_cfg_if.sv
display_timing.sv
sprite_regs.sv
sprite_bitmap.sv
sprite_engine.sv
pixel_mixer.sv
sprite_top.sv
tb_sprite.sv

// ==== sprite_bitmap.sv ====
/* 8x8 one bit per pixel sprite bitmap, written a row at a time
   contents are undefined until written, both reads are combinational */
`include "sprite_defines.svh"

module sprite_bitmap (
    input  logic                    clk,
    input  logic                    bmp_we,     // row write strobe
    input  sprite_pkg::row_t        bmp_wrow,   // bus row
    input  sprite_pkg::bmp_row_t    bmp_wdata,
    output sprite_pkg::bmp_row_t    bmp_rdata,  // readback of bus row
    input  sprite_pkg::row_t        pix_row,    // engine row
    input  sprite_pkg::col_t        pix_col,    // engine column
    output logic                    pix_bit
);

    sprite_pkg::bmp_row_t mem [`SPR_H];  // bit c of a row is column c

    always_ff @(posedge clk) begin
        if (bmp_we) begin
            mem[bmp_wrow] <= bmp_wdata;
        end
    end

    // readback for APB
    assign bmp_rdata = mem[bmp_wrow];

    // single pixel for the engine, same cycle
    assign pix_bit = mem[pix_row][pix_col];

endmodule

// ==== sprite_cfg_if.sv ====
/* sprite configuration from the register block to engine and mixer
   values are live, the engine samples them at sprite start */
interface sprite_cfg_if;

    logic                   enable;      // sprite on
    sprite_pkg::coord_t     sprx;        // left edge
    sprite_pkg::coord_t     spry;        // top line
    sprite_pkg::scale_t     scale_x;     // pixel repeat - 1
    sprite_pkg::scale_t     scale_y;     // line repeat - 1
    sprite_pkg::colour_t    spr_colour;  // foreground
    sprite_pkg::colour_t    bg_colour;   // background

    modport regs (
        output enable, sprx, spry, scale_x, scale_y, spr_colour, bg_colour
    );

    modport engine (
        input enable, sprx, spry, scale_x, scale_y
    );

    modport mixer (
        input spr_colour, bg_colour
    );

endinterface

// ==== sprite_defines.svh ====
/* raster, sprite and register map constants for the sprite display
   sprites must lie fully inside the active area, there is no clipping */
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// horizontal raster in pixels
`define H_ACTIVE 32
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 40

// vertical raster in lines
`define V_ACTIVE 24
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 28

`define CORDW 6       // screen coordinate width
`define SPR_W 8       // bitmap width in pixels
`define SPR_H 8       // bitmap height in rows
`define COLRW 4       // colour width
`define MAX_SCALE 4   // largest scale factor

// APB register offsets
`define REG_CTRL 'h00
`define REG_SPRX 'h04
`define REG_SPRY 'h08
`define REG_COLR 'h0C
`define REG_BMP 'h40  // rows at 'h40 + 4*row

`endif

// ==== sprite_engine.sv ====
/* sprite drawing FSM, one sprite per frame with 1x to 4x scaling
   armed on the line before spry, position and scale sampled at START */
`include "sprite_defines.svh"

module sprite_engine (
    input  logic                clk,
    input  logic                rst,
    sprite_cfg_if.engine        cfg,
    input  sprite_pkg::coord_t  sx,
    input  sprite_pkg::coord_t  sy,
    input  logic                line_arm,  // end of active line
    output sprite_pkg::row_t    pix_row,   // bitmap address
    output sprite_pkg::col_t    pix_col,
    input  logic                pix_bit,   // bitmap data, same cycle
    output logic                pix        // sprite pixel on
);

    sprite_pkg::engine_state_t state, state_next;

    sprite_pkg::col_t   col;        // position in bitmap
    sprite_pkg::row_t   row;
    sprite_pkg::scale_t cnt_x;      // pixel repeat count
    sprite_pkg::scale_t cnt_y;      // line repeat count

    sprite_pkg::coord_t sprx_q;     // sampled at START
    sprite_pkg::scale_t scale_x_q;
    sprite_pkg::scale_t scale_y_q;

    sprite_pkg::coord_t sprx_cor;   // pixel before left edge
    sprite_pkg::coord_t spry_cor;   // line before top edge
    logic               start;
    logic               last_pixel;
    logic               last_line;

    always_comb begin
        spry_cor   = (cfg.spry == '0) ? sprite_pkg::coord_t'(`V_TOTAL - 1)
                                      : sprite_pkg::coord_t'(cfg.spry - 1'b1);
        sprx_cor   = (sprx_q == '0) ? sprite_pkg::coord_t'(`H_TOTAL - 1)
                                    : sprite_pkg::coord_t'(sprx_q - 1'b1);
        start      = line_arm && cfg.enable && (sy == spry_cor);
        last_pixel = (col == sprite_pkg::col_t'(`SPR_W - 1)) && (cnt_x == scale_x_q);
        last_line  = (row == sprite_pkg::row_t'(`SPR_H - 1)) && (cnt_y == scale_y_q);
    end

    // next state
    always_comb begin
        case (state)
            sprite_pkg::IDLE:      state_next = start ? sprite_pkg::START : sprite_pkg::IDLE;
            sprite_pkg::START:     state_next = sprite_pkg::AWAIT_POS;
            sprite_pkg::AWAIT_POS: state_next = (sx == sprx_cor) ? sprite_pkg::DRAW
                                                                 : sprite_pkg::AWAIT_POS;
            sprite_pkg::DRAW: begin
                if (!last_pixel) begin
                    state_next = sprite_pkg::DRAW;
                end else begin
                    state_next = last_line ? sprite_pkg::IDLE : sprite_pkg::NEXT_LINE;
                end
            end
            sprite_pkg::NEXT_LINE: state_next = sprite_pkg::AWAIT_POS;
            default:               state_next = sprite_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sprite_pkg::IDLE;
            col   <= '0;
            row   <= '0;
            cnt_x <= '0;
            cnt_y <= '0;
        end else begin
            state <= state_next;
            case (state)
                sprite_pkg::START: begin
                    row   <= '0;  // top of bitmap
                    cnt_y <= '0;
                end
                sprite_pkg::AWAIT_POS: begin
                    col   <= '0;  // left of row
                    cnt_x <= '0;
                end
                sprite_pkg::DRAW: begin
                    if (cnt_x == scale_x_q) begin
                        col   <= col + 1'b1;  // next column
                        cnt_x <= '0;
                    end else begin
                        cnt_x <= cnt_x + 1'b1;  // repeat pixel
                    end
                end
                sprite_pkg::NEXT_LINE: begin
                    if (cnt_y == scale_y_q) begin
                        row   <= row + 1'b1;
                        cnt_y <= '0;
                    end else begin
                        cnt_y <= cnt_y + 1'b1;  // same row again
                    end
                end
                default: ;
            endcase
        end
    end

    // position and scale held for the whole sprite
    always_ff @(posedge clk) begin
        if (state == sprite_pkg::START) begin
            sprx_q    <= cfg.sprx;
            scale_x_q <= cfg.scale_x;
            scale_y_q <= cfg.scale_y;
        end
    end

    assign pix_row = row;
    assign pix_col = col;
    assign pix     = (state == sprite_pkg::DRAW) ? pix_bit : 1'b0;

    // sprite pixels only inside the active area
    a_pix_active: assert property (
        @(posedge clk) disable iff (rst)
        pix |-> (sx < `H_ACTIVE) && (sy < `V_ACTIVE)
    );

    // START one pixel after line_arm
    a_start_after_arm: assert property (
        @(posedge clk) disable iff (rst)
        (state == sprite_pkg::START) |-> (sx == sprite_pkg::coord_t'(`H_ACTIVE + 1))
    );

endmodule

// ==== sprite_pkg.sv ====
/* shared types for the sprite display
   scale values are stored as factor minus one */
`include "sprite_defines.svh"

package sprite_pkg;

    // screen position, covers the whole raster incl. blanking
    typedef logic [`CORDW-1:0] coord_t;

    // pixel colour
    typedef logic [`COLRW-1:0] colour_t;

    // 0..3 means 1x..4x
    typedef logic [$clog2(`MAX_SCALE)-1:0] scale_t;

    typedef logic [$clog2(`SPR_H)-1:0] row_t;   // bitmap row index
    typedef logic [$clog2(`SPR_W)-1:0] col_t;   // bitmap column index
    typedef logic [`SPR_W-1:0] bmp_row_t;       // one bitmap row, bit c = column c

    // APB3 bus fields
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // sprite engine states
    typedef enum logic [2:0] {
        IDLE,       // waiting for line before sprite
        START,      // latch position and scale
        AWAIT_POS,  // wait for horizontal start
        DRAW,       // output bitmap pixels
        NEXT_LINE   // step or repeat row
    } engine_state_t;

endpackage

// ==== sprite_regs.sv ====
/* APB3 slave for the sprite registers and bitmap window
   no wait states, unmapped offsets give pslverr and are ignored */
`include "sprite_defines.svh"

module sprite_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  sprite_pkg::apb_addr_t   paddr,
    input  sprite_pkg::apb_data_t   pwdata,
    output sprite_pkg::apb_data_t   prdata,
    output logic                    pready,
    output logic                    pslverr,
    sprite_cfg_if.regs              cfg,
    output logic                    bmp_we,     // bitmap row write
    output sprite_pkg::row_t        bmp_wrow,   // row for write and readback
    output sprite_pkg::bmp_row_t    bmp_wdata,
    input  sprite_pkg::bmp_row_t    bmp_rdata
);

    logic access;   // access phase
    logic wr_en;    // write completes this cycle
    logic reg_hit;  // one of the four config registers
    logic bmp_hit;  // inside bitmap window
    logic hit;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_comb begin
        reg_hit = (paddr == `REG_CTRL) || (paddr == `REG_SPRX) ||
                  (paddr == `REG_SPRY) || (paddr == `REG_COLR);
        bmp_hit = (paddr >= sprite_pkg::apb_addr_t'(`REG_BMP)) &&
                  (paddr < sprite_pkg::apb_addr_t'(`REG_BMP + 4 * `SPR_H)) &&
                  (paddr[1:0] == 2'b00);  // word aligned rows only
        hit     = reg_hit || bmp_hit;
    end

    // bitmap window goes straight through to the storage
    assign bmp_wrow  = sprite_pkg::row_t'((paddr - sprite_pkg::apb_addr_t'(`REG_BMP)) >> 2);
    assign bmp_wdata = pwdata[`SPR_W-1:0];
    assign bmp_we    = wr_en && bmp_hit;

    assign pready  = 1'b1;            // never waits
    assign pslverr = access && !hit;  // flagged in access cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.enable     <= 1'b0;
            cfg.scale_x    <= '0;
            cfg.scale_y    <= '0;
            cfg.sprx       <= '0;
            cfg.spry       <= '0;
            cfg.spr_colour <= '0;
            cfg.bg_colour  <= '0;
        end else if (wr_en) begin
            case (paddr)
                `REG_CTRL: begin
                    cfg.enable  <= pwdata[0];
                    cfg.scale_x <= pwdata[5:4];
                    cfg.scale_y <= pwdata[7:6];
                end
                `REG_SPRX: cfg.sprx <= pwdata[`CORDW-1:0];
                `REG_SPRY: cfg.spry <= pwdata[`CORDW-1:0];
                `REG_COLR: begin
                    cfg.spr_colour <= pwdata[`COLRW-1:0];
                    cfg.bg_colour  <= pwdata[2*`COLRW-1:`COLRW];
                end
                default: ;  // bitmap or unmapped
            endcase
        end
    end

    // read mux, unused bits zero
    always_comb begin
        case (paddr)
            `REG_CTRL: prdata = sprite_pkg::apb_data_t'(
                {cfg.scale_y, cfg.scale_x, 3'b000, cfg.enable});
            `REG_SPRX: prdata = sprite_pkg::apb_data_t'(cfg.sprx);
            `REG_SPRY: prdata = sprite_pkg::apb_data_t'(cfg.spry);
            `REG_COLR: prdata = sprite_pkg::apb_data_t'({cfg.bg_colour, cfg.spr_colour});
            default:   prdata = bmp_hit ? sprite_pkg::apb_data_t'(bmp_rdata) : '0;
        endcase
    end

    // access phase must follow a selected setup phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    );

endmodule

// ==== sprite_top.sv ====
/* single sprite display with APB3 configuration
   video outputs follow the raster with one cycle of latency */
module sprite_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  sprite_pkg::apb_addr_t   paddr,
    input  sprite_pkg::apb_data_t   pwdata,
    output sprite_pkg::apb_data_t   prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output sprite_pkg::colour_t     colour
);

    sprite_pkg::coord_t     sx, sy;      // raster position
    logic                   hsync_raw;   // before output register
    logic                   vsync_raw;
    logic                   de_raw;
    logic                   line_arm;

    logic                   bmp_we;
    sprite_pkg::row_t       bmp_wrow;
    sprite_pkg::bmp_row_t   bmp_wdata;
    sprite_pkg::bmp_row_t   bmp_rdata;

    sprite_pkg::row_t       pix_row;
    sprite_pkg::col_t       pix_col;
    logic                   pix_bit;
    logic                   pix;

    sprite_cfg_if cfg_bus ();

    display_timing timing0 (
        .clk(clk), .rst(rst), .sx(sx), .sy(sy),
        .hsync(hsync_raw), .vsync(vsync_raw), .de(de_raw), .line_arm(line_arm)
    );

    sprite_regs regs0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg(cfg_bus.regs),
        .bmp_we(bmp_we), .bmp_wrow(bmp_wrow), .bmp_wdata(bmp_wdata), .bmp_rdata(bmp_rdata)
    );

    sprite_bitmap bitmap0 (
        .clk(clk),
        .bmp_we(bmp_we), .bmp_wrow(bmp_wrow), .bmp_wdata(bmp_wdata), .bmp_rdata(bmp_rdata),
        .pix_row(pix_row), .pix_col(pix_col), .pix_bit(pix_bit)
    );

    sprite_engine engine0 (
        .clk(clk), .rst(rst), .cfg(cfg_bus.engine),
        .sx(sx), .sy(sy), .line_arm(line_arm),
        .pix_row(pix_row), .pix_col(pix_col), .pix_bit(pix_bit), .pix(pix)
    );

    pixel_mixer mixer0 (
        .clk(clk), .rst(rst), .cfg(cfg_bus.mixer), .pix(pix),
        .hsync_in(hsync_raw), .vsync_in(vsync_raw), .de_in(de_raw),
        .hsync(hsync), .vsync(vsync), .de(de), .colour(colour)
    );

endmodule

// ==== tb_sprite.sv ====
/* testbench for sprite_top, random register values from an xorshift generator
   every output cycle is compared with a raster and colour model of the display
   sprites are kept inside the active area, colour is checked only once configured */
`include "sprite_defines.svh"

module tb_sprite;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS      = 100;
    localparam int DRIVE_NS    = 10;   // input skew after rising edge
    localparam int FRAME_NS    = `H_TOTAL * `V_TOTAL * CLK_NS;
    localparam int WATCHDOG_NS = 12 * FRAME_NS;  // run needs about 8 frames

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    sprite_pkg::apb_addr_t  paddr;
    sprite_pkg::apb_data_t  pwdata;
    sprite_pkg::apb_data_t  prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   hsync;
    logic                   vsync;
    logic                   de;
    sprite_pkg::colour_t    colour;

    logic [31:0] rng;          // xorshift state
    logic [7:0]  shadow [12];  // ctrl, sprx, spry, colr, then bitmap rows 0..7
    string       test_name;
    bit          valid;        // outputs show a counted raster position
    bit          chk_colour;   // sprite config is settled
    int          mx;           // model position of the outputs
    int          my;

    sprite_top dut0 (.*);

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // slots 0..3 config, 4..11 bitmap rows
    function automatic sprite_pkg::apb_addr_t slot_addr(input int slot);
        return (slot < 4) ? 8'(4 * slot) : 8'(`REG_BMP + 4 * (slot - 4));
    endfunction

    function automatic logic [7:0] field_mask(input int slot);
        case (slot)
            0:       return 8'hF1;  // scale_y, scale_x, enable
            1, 2:    return 8'h3F;  // positions
            default: return 8'hFF;  // colours and rows
        endcase
    endfunction

    // pixel in sprite when dx, dy fall inside the scaled box
    function automatic sprite_pkg::colour_t expected_colour(input int x, input int y);
        int fx;
        int fy;
        int dx;
        int dy;
        logic [7:0] row;
        fx = int'(shadow[0][5:4]) + 1;
        fy = int'(shadow[0][7:6]) + 1;
        dx = x - int'(shadow[1]);
        dy = y - int'(shadow[2]);
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
            return '0;  // blanking
        end
        if (shadow[0][0] && dx >= 0 && dx < `SPR_W * fx && dy >= 0 && dy < `SPR_H * fy) begin
            row = shadow[4 + dy / fy];
            if (row[dx / fx]) begin
                return shadow[3][3:0];  // sprite colour
            end
        end
        return shadow[3][7:4];  // background
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s expected %0h actual %0h", name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "mismatch in %s", name);
    endtask

    // setup cycle, access cycle, response taken mid access cycle
    task automatic apb_transfer(input logic wr, input sprite_pkg::apb_addr_t addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #DRIVE_NS;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_NS;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        assert (pready === 1'b1) else report_mismatch({test_name, " pready"}, 1, pready);
        @(posedge clk);  // transfer completes here
        #DRIVE_NS;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input int slot, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b1, slot_addr(slot), data, rd, err);
        assert (err === 1'b0) else report_mismatch({test_name, " write pslverr"}, 0, err);
        shadow[slot] = data[7:0] & field_mask(slot);  // model copy
    endtask

    task automatic expect_read(input int slot);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b0, slot_addr(slot), '0, rd, err);
        assert (err === 1'b0) else report_mismatch({test_name, " read pslverr"}, 0, err);
        assert (rd === 32'(shadow[slot])) else report_mismatch(test_name, shadow[slot], rd);
    endtask

    task automatic wait_for_line(input int line);
        do begin
            @(negedge clk);
        end while (!(valid && mx == 0 && my == line));
    endtask

    // random position and bitmap, placed fully inside the active area
    task automatic program_sprite(input int scx, input int scy);
        int lim_x;
        int lim_y;
        lim_x = `H_ACTIVE - `SPR_W * (scx + 1);
        lim_y = `V_ACTIVE - `SPR_H * (scy + 1);
        write_reg(1, rand_word() % (lim_x + 1));
        write_reg(2, rand_word() % (lim_y + 1));
        write_reg(3, rand_word());  // both colours
        for (int r = 0; r < `SPR_H; r++) begin
            write_reg(4 + r, rand_word());
        end
        write_reg(0, {24'd0, 2'(scy), 2'(scx), 4'b0001});
        expect_read(0);  // enable bit readback
    endtask

    // output raster, one cycle behind the DUT counters
    always @(posedge clk) begin
        if (rst) begin
            valid = 1'b0;
        end else if (!valid) begin
            valid = 1'b1;  // first pixel out of reset
            mx    = 0;
            my    = 0;
        end else if (mx == `H_TOTAL - 1) begin
            mx = 0;
            my = (my == `V_TOTAL - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
    end

    always @(negedge clk) begin : check_outputs
        logic [2:0]          exp_sync;  // hsync, vsync, de
        sprite_pkg::colour_t exp_col;
        if (!valid) begin
            assert ({hsync, vsync, de, colour, pslverr} === '0)
                else report_mismatch("reset_state", 0, {hsync, vsync, de, colour, pslverr});
        end else begin
            exp_sync[2] = (mx >= `H_ACTIVE + `H_FRONT) &&
                          (mx < `H_ACTIVE + `H_FRONT + `H_SYNC);
            exp_sync[1] = (my >= `V_ACTIVE + `V_FRONT) &&
                          (my < `V_ACTIVE + `V_FRONT + `V_SYNC);
            exp_sync[0] = (mx < `H_ACTIVE) && (my < `V_ACTIVE);
            assert ({hsync, vsync, de} === exp_sync)
                else report_mismatch("raster_timing", exp_sync, {hsync, vsync, de});
            exp_col = expected_colour(mx, my);
            assert (!chk_colour || colour === exp_col)
                else report_mismatch(test_name, exp_col, colour);
        end
    end

    initial begin : watchdog
        #WATCHDOG_NS;
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired, stimulus did not finish within 12 frames");
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rng        = 32'd99;
        chk_colour = 1'b0;
        test_name  = "reset_state";
        repeat (8) @(posedge clk);
        #DRIVE_NS;
        rst = 1'b0;

        test_name = "apb_register_access";
        for (int s = 0; s < 12; s++) begin
            write_reg(s, (s == 0) ? (rand_word() & ~32'h1) : rand_word());  // sprite stays off
            expect_read(s);
        end
        apb_transfer(1'b1, 8'h20, rand_word(), rd, err);  // hole in the map
        assert (err === 1'b1) else report_mismatch("unmapped_write pslverr", 1, err);
        apb_transfer(1'b0, 8'h20, '0, rd, err);
        assert (err === 1'b1) else report_mismatch("unmapped_read pslverr", 1, err);
        for (int s = 0; s < 12; s++) begin
            expect_read(s);  // nothing changed
        end

        test_name = "unscaled_sprite";
        wait_for_line(`V_ACTIVE);  // vertical blanking
        program_sprite(0, 0);
        chk_colour = 1'b1;
        repeat (2) wait_for_line(`V_ACTIVE);  // two full frames

        test_name = "scaled_sprite";
        program_sprite(int'(rand_word() % 4), int'(rand_word() % 3));  // 4x height cannot fit
        wait_for_line(`V_ACTIVE);

        test_name = "disable";
        write_reg(0, shadow[0] & 8'hF0);
        wait_for_line(`V_ACTIVE);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
